/* project.f */
verilog/clk_div_pkg.sv
verilog/rst_sync.sv
verilog/cfg_handshake.sv
verilog/clock_divider.sv
verilog/clk_div_top.sv
testbench/clk_div_properties.sv
testbench/tb_clk_div_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the clock-divider testbench with Verilator and runs it.
# The exit status is nonzero if the build fails or the simulation stops on $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_clk_div_top \
    --Mdir obj_dir \
    -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

if [ ! -x ./obj_dir/Vtb_clk_div_top ]; then
    echo "Simulation executable not found"
    exit 1
fi

./obj_dir/Vtb_clk_div_top
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

/* testbench/clk_div_properties.sv */
// Concurrent checks on the cfg handshake FSM and its reset state
// Bound into every cfg_handshake instance
`timescale 1ns/1ps

module clk_div_properties import clk_div_pkg::*; #(
    parameter int NUM_CH = 2
) (
    input logic              clk,
    input logic              sync_rst,
    input logic              cfg_req,
    input logic              cfg_ack,
    input logic              cfg_err,
    input logic [NUM_CH-1:0] ld_en,
    input cfg_state_t        state
);

    // Ack only rises out of idle, so a held request is acknowledged once
    a_ack_once: assert property (@(posedge clk) disable iff (sync_rst)
        $rose(cfg_ack) |-> ($past(state) == CFG_IDLE))
        else $error("cfg_ack rose outside CFG_IDLE");

    // Ack drops only once the requester has let go
    a_ack_release: assert property (@(posedge clk) disable iff (sync_rst)
        $fell(cfg_ack) |-> !$past(cfg_req))
        else $error("cfg_ack fell while cfg_req was high");

    a_err_with_ack: assert property (@(posedge clk) disable iff (sync_rst)
        cfg_err |-> cfg_ack)
        else $error("cfg_err high without cfg_ack");

    // Rejected writes never reach a channel
    a_no_load_on_err: assert property (@(posedge clk) disable iff (sync_rst)
        !((|ld_en) && cfg_err))
        else $error("ld_en active together with cfg_err");

    // Held in reset, the port is idle and quiet
    a_reset_idle: assert property (@(posedge clk)
        sync_rst |-> (!cfg_ack && !cfg_err && (ld_en == '0) && (state == CFG_IDLE)))
        else $error("cfg port not idle during reset");

endmodule

bind cfg_handshake clk_div_properties #(
    .NUM_CH (NUM_CH)
) i_props (
    .clk      (clk),
    .sync_rst (sync_rst),
    .cfg_req  (cfg_req),
    .cfg_ack  (cfg_ack),
    .cfg_err  (cfg_err),
    .ld_en    (ld_en),
    .state    (state)
);

/* testbench/tb_clk_div_top.sv */
// Directed testbench for the clock-divider subsystem
// Drives the cfg port on falling clk edges and times every clk_out in clk cycles
`timescale 1ns/1ps

module tb_clk_div_top import clk_div_pkg::*; ();

    localparam int NUM_CH     = 2;
    localparam int SEL_W      = $clog2(NUM_CH + 1);
    // Divisor every channel runs at after reset
    localparam int RESET_DIV  = 8;
    // Cycle budgets for the wait loops
    localparam int ACK_LIMIT  = 20;
    localparam int WAIT_LIMIT = 600;

    logic              clk;
    logic              async_rst;
    logic              cfg_req;
    logic [SEL_W-1:0]  cfg_sel;
    div_t              cfg_div;
    logic              cfg_ack;
    logic              cfg_err;
    logic [NUM_CH-1:0] clk_out;

    // Free-running count of rising clk edges that is read only on falling edges
    int unsigned cyc = 0;

    clk_div_top i_dut (
        .clk       (clk),
        .async_rst (async_rst),
        .cfg_req   (cfg_req),
        .cfg_sel   (cfg_sel),
        .cfg_div   (cfg_div),
        .cfg_ack   (cfg_ack),
        .cfg_err   (cfg_err),
        .clk_out   (clk_out)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // Full four-phase write with req held for hold extra cycles after ack
    // Returns the cycle count at which ack was first seen
    task automatic cfg_write(input int sel, input int div, input int hold,
                             input logic exp_err, output int unsigned ack_cyc);
        int n;
        cfg_sel = SEL_W'(sel);
        cfg_div = div_t'(div);
        cfg_req = 1'b1;
        n = 0;
        while (!cfg_ack) begin
            if (n == ACK_LIMIT) begin
                abort_run("Timeout waiting for cfg_ack to rise");
            end
            @(negedge clk);
            n++;
        end
        // Ack comes on the first edge that sees req
        check_val("cfg_ack rise delay", n, 1);
        ack_cyc = cyc;
        check_val("cfg_err", 32'(cfg_err), 32'(exp_err));
        // Ack must stay up as long as req is held
        repeat (hold) begin
            @(negedge clk);
            check_val("cfg_ack", 32'(cfg_ack), 32'd1);
            check_val("cfg_err", 32'(cfg_err), 32'(exp_err));
        end
        cfg_req = 1'b0;
        n = 0;
        while (cfg_ack) begin
            if (n == ACK_LIMIT) begin
                abort_run("Timeout waiting for cfg_ack to fall");
            end
            @(negedge clk);
            n++;
        end
        check_val("cfg_ack fall delay", n, 1);
        check_val("cfg_err", 32'(cfg_err), 32'd0);
    endtask

    // Waits for the next low-to-high step of one output
    task automatic wait_rise(input int ch, output int unsigned at_cyc);
        logic prev;
        logic found;
        int   n;
        prev   = clk_out[ch];
        found  = 1'b0;
        n      = 0;
        at_cyc = 0;
        while (!found) begin
            if (n == WAIT_LIMIT) begin
                abort_run($sformatf("Timeout waiting for clk_out[%0d] to rise", ch));
            end
            @(negedge clk);
            n++;
            if (!prev && clk_out[ch]) begin
                found  = 1'b1;
                at_cyc = cyc;
            end
            prev = clk_out[ch];
        end
    endtask

    // Period between two rising edges in clk cycles
    task automatic check_period(input int ch, input int exp_div);
        int unsigned t0;
        int unsigned t1;
        wait_rise(ch, t0);
        wait_rise(ch, t1);
        check_val($sformatf("clk_out[%0d] period", ch), t1 - t0, exp_div);
    endtask

    // Accepted write followed by first-edge delay and period of the new divisor
    task automatic load_and_check(input int ch, input int div);
        int unsigned ack_cyc;
        int unsigned rise_cyc;
        cfg_write(ch, div, 0, 1'b0, ack_cyc);
        wait_rise(ch, rise_cyc);
        // Load lands one edge after ack and the first rise div/2 edges later
        check_val($sformatf("clk_out[%0d] first rise delay", ch),
                  rise_cyc - ack_cyc, 1 + div / 2);
        check_period(ch, div);
    endtask

    // Output must stay low for the whole window
    task automatic check_low(input int ch, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_val($sformatf("clk_out[%0d]", ch), 32'(clk_out[ch]), 32'd0);
        end
    endtask

    task automatic test_reset();
        repeat (10) @(negedge clk);
        check_val("cfg_ack", 32'(cfg_ack), 32'd0);
        check_val("cfg_err", 32'(cfg_err), 32'd0);
        check_val("clk_out", 32'(clk_out), 32'd0);
        async_rst = 1'b0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            check_period(ch, RESET_DIV);
        end
    endtask

    task automatic test_accept();
        load_and_check(1, 4);
        check_period(0, RESET_DIV);
        load_and_check(1, 12);
        check_period(0, RESET_DIV);
    endtask

    task automatic test_reject();
        int unsigned ack_cyc;
        cfg_write(1, 5, 0, 1'b1, ack_cyc);
        cfg_write(1, 1, 0, 1'b1, ack_cyc);
        // Index just past the last channel
        cfg_write(NUM_CH, 6, 0, 1'b1, ack_cyc);
        check_period(1, 12);
        check_period(0, RESET_DIV);
    endtask

    task automatic test_stop();
        int unsigned ack_cyc;
        cfg_write(1, 0, 0, 1'b0, ack_cyc);
        check_low(1, 64);
        check_period(0, RESET_DIV);
        load_and_check(1, 6);
    endtask

    task automatic test_handshake();
        int unsigned ack_cyc;
        int d0;
        int d1;
        cfg_write(0, 10, 6, 1'b0, ack_cyc);
        check_period(0, 10);
        // Each write starts right after the previous ack drops
        repeat (3) begin
            d0 = 2 * (int'($urandom % 15) + 1);
            d1 = 2 * (int'($urandom % 15) + 1);
            cfg_write(0, d0, 0, 1'b0, ack_cyc);
            cfg_write(1, d1, 0, 1'b0, ack_cyc);
            check_period(0, d0);
            check_period(1, d1);
        end
    endtask

    initial begin
        clk       = 1'b0;
        async_rst = 1'b1;
        cfg_req   = 1'b0;
        cfg_sel   = '0;
        cfg_div   = '0;
        void'($urandom(32'h7f17cf06));
        test_reset();
        test_accept();
        test_reject();
        test_stop();
        test_handshake();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verilog/cfg_handshake.sv */
// Four-phase req/ack configuration port, validates each divisor write
// Accepted writes leave as a one-cycle load pulse to the selected channel
`timescale 1ns/1ps

module cfg_handshake import clk_div_pkg::*; #(
    parameter int NUM_CH = 2,
    // Wide enough to also carry the out-of-range index NUM_CH
    localparam int SEL_W = $clog2(NUM_CH + 1)
) (
    input  logic              clk,
    input  logic              sync_rst,
    input  logic              cfg_req,
    input  logic [SEL_W-1:0]  cfg_sel,
    input  div_t              cfg_div,
    output logic              cfg_ack,
    output logic              cfg_err,
    output half_t             ld_half,
    output logic [NUM_CH-1:0] ld_en
);

    cfg_state_t state;
    cfg_state_t state_nxt;

    // Request checks
    logic div_odd;
    logic sel_bad;
    logic req_bad;

    // Handshake events
    logic take;
    logic release_seen;

    // Decoded channel select
    logic [NUM_CH-1:0] sel_onehot;

    // Odd divisors cannot give a 50% duty output
    // A divisor of 1 is odd as well, so it lands here too
    assign div_odd = cfg_div[0];
    assign sel_bad = (cfg_sel >= SEL_W'(NUM_CH));
    assign req_bad = div_odd | sel_bad;

    // New request seen while idle, evaluated exactly once per request
    assign take = (state == CFG_IDLE) && cfg_req;

    // Requester has dropped req while ack is up
    assign release_seen = (state != CFG_IDLE) && !cfg_req;

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            sel_onehot[i] = (cfg_sel == SEL_W'(i));
        end
    end

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            CFG_IDLE: begin
                if (cfg_req) begin
                    state_nxt = CFG_ACK;
                end
            end
            CFG_ACK: begin
                // Requester may already have let go in the first ack cycle
                state_nxt = cfg_req ? CFG_WAIT_REL : CFG_IDLE;
            end
            CFG_WAIT_REL: begin
                if (!cfg_req) begin
                    state_nxt = CFG_IDLE;
                end
            end
            default: begin
                state_nxt = CFG_IDLE;
            end
        endcase
    end

    // State and registered handshake outputs
    always_ff @(posedge clk or posedge sync_rst) begin
        if (sync_rst) begin
            state   <= CFG_IDLE;
            cfg_ack <= 1'b0;
            cfg_err <= 1'b0;
            ld_en   <= '0;
        end else begin
            state <= state_nxt;

            // Load pulse rises with ack and lasts a single cycle
            if (take && !req_bad) begin
                ld_en <= sel_onehot;
            end else begin
                ld_en <= '0;
            end

            // Error is latched with ack and held until ack drops
            if (take) begin
                cfg_ack <= 1'b1;
                cfg_err <= req_bad;
            end else if (release_seen) begin
                cfg_ack <= 1'b0;
                cfg_err <= 1'b0;
            end
        end
    end

    // Halved divisor, only looked at by a channel while its ld_en is high
    always_ff @(posedge clk) begin
        if (take) begin
            ld_half <= cfg_div[DIV_W-1:1];
        end
    end

endmodule

/* verilog/clk_div_pkg.sv */
// Shared widths, divisor types and FSM encoding for the clock-divider subsystem
// Imported by wildcard into every module that needs one of these definitions

package clk_div_pkg;

    // Width of a full-period divisor in clk cycles
    localparam int DIV_W = 8;

    // Full output period, counted in clk cycles
    // Even values of 2 and up divide, zero stops the channel
    typedef logic [DIV_W-1:0] div_t;

    // Half period, i.e. the divisor with its always-zero LSB dropped
    typedef logic [DIV_W-2:0] half_t;

    // Divisor every channel runs at after reset
    // Must be even or zero, since the LSB is discarded on the way in
    localparam div_t DIV_DEFAULT = div_t'(8);

    // Four-phase handshake receiver states
    typedef enum logic [1:0] {
        // Waiting for cfg_req to rise
        CFG_IDLE     = 2'd0,
        // First cycle of ack, load pulse is out
        CFG_ACK      = 2'd1,
        // Holding ack until the requester lets go of cfg_req
        CFG_WAIT_REL = 2'd2
    } cfg_state_t;

endpackage

/* verilog/clk_div_top.sv */
// Clock-divider subsystem top, NUM_CH divided outputs of clk
// Divisors are rewritten at run time over the four-phase cfg port
`timescale 1ns/1ps

module clk_div_top import clk_div_pkg::*; #(
    parameter int   NUM_CH      = 2,
    parameter int   SYNC_STAGES = 5,
    parameter div_t DEFAULT_DIV = DIV_DEFAULT,
    // Channel index width, one extra code so bad indices can be reported
    localparam int  SEL_W       = $clog2(NUM_CH + 1)
) (
    input  logic              clk,
    input  logic              async_rst,
    input  logic              cfg_req,
    input  logic [SEL_W-1:0]  cfg_sel,
    input  div_t              cfg_div,
    output logic              cfg_ack,
    output logic              cfg_err,
    output logic [NUM_CH-1:0] clk_out
);

    // Synchronized reset for all clocked logic
    logic sync_rst;

    // Load bus from the cfg port, half period is shared by all channels
    half_t             ld_half;
    logic [NUM_CH-1:0] ld_en;

    rst_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_rst_sync (
        .clk       (clk),
        .async_rst (async_rst),
        .sync_rst  (sync_rst)
    );

    cfg_handshake #(
        .NUM_CH (NUM_CH)
    ) i_cfg (
        .clk      (clk),
        .sync_rst (sync_rst),
        .cfg_req  (cfg_req),
        .cfg_sel  (cfg_sel),
        .cfg_div  (cfg_div),
        .cfg_ack  (cfg_ack),
        .cfg_err  (cfg_err),
        .ld_half  (ld_half),
        .ld_en    (ld_en)
    );

    // One divider per output, each picks its own bit of the one-hot load
    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
        clock_divider #(
            .DEFAULT_DIV (DEFAULT_DIV)
        ) i_div (
            .clk      (clk),
            .sync_rst (sync_rst),
            .ld_half  (ld_half),
            .ld_en    (ld_en[ch]),
            .clk_out  (clk_out[ch])
        );
    end

endmodule

/* verilog/clock_divider.sv */
// One divider channel with a run-time half period, 50% duty output
// Loaded from the configuration port, restarts from low on every load
`timescale 1ns/1ps

module clock_divider import clk_div_pkg::*; #(
    // Full period used from reset until the first load
    parameter div_t DEFAULT_DIV = DIV_DEFAULT
) (
    input  logic  clk,
    input  logic  sync_rst,
    input  half_t ld_half,
    input  logic  ld_en,
    output logic  clk_out
);

    // Reset value of the half period, LSB of an even divisor is zero
    localparam half_t DEFAULT_HALF = DEFAULT_DIV[DIV_W-1:1];

    // Current half period, zero means stopped
    half_t half_q;

    // Cycles spent in the current output phase
    half_t cnt_q;

    // Terminal count of a phase
    half_t cnt_last;

    // Channel is dividing, i.e. a non-zero half period is loaded
    logic running;

    // Last cycle of the current phase, output flips on the next edge
    logic phase_end;

    assign running   = (half_q != '0);
    assign cnt_last  = half_q - half_t'(1);
    assign phase_end = running && (cnt_q == cnt_last);

    // Half-period register, written only by a load
    always_ff @(posedge clk or posedge sync_rst) begin
        if (sync_rst) begin
            half_q <= DEFAULT_HALF;
        end else if (ld_en) begin
            half_q <= ld_half;
        end
    end

    // Phase counter
    // Counts 0 .. half-1 and wraps, parked at zero while stopped
    always_ff @(posedge clk or posedge sync_rst) begin
        if (sync_rst) begin
            cnt_q <= '0;
        end else if (ld_en) begin
            // New divisor starts a fresh low phase
            cnt_q <= '0;
        end else if (!running) begin
            cnt_q <= '0;
        end else if (phase_end) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + half_t'(1);
        end
    end

    // Registered output
    // First rise comes half cycles after reset release or a load
    always_ff @(posedge clk or posedge sync_rst) begin
        if (sync_rst) begin
            clk_out <= 1'b0;
        end else if (ld_en) begin
            clk_out <= 1'b0;
        end else if (!running) begin
            // Stopped channel holds low
            clk_out <= 1'b0;
        end else if (phase_end) begin
            clk_out <= ~clk_out;
        end
    end

endmodule

/* verilog/rst_sync.sv */
// Reset synchronizer, asserts as soon as async_rst rises and releases on clk
// Its output resets every clocked block of the divider subsystem
`timescale 1ns/1ps

module rst_sync #(
    // Number of flops in the release chain
    parameter int SYNC_STAGES = 5
) (
    input  logic clk,
    input  logic async_rst,
    output logic sync_rst
);

    // Release chain, MSB is the reset seen by the rest of the design
    logic [SYNC_STAGES-1:0] rst_chain;

    // Preset to all ones while async_rst is high
    // Then zeros walk in from the LSB, one stage per clk edge
    always_ff @(posedge clk or posedge async_rst) begin
        if (async_rst) begin
            rst_chain <= '1;
        end else begin
            rst_chain <= rst_chain << 1;
        end
    end

    // Goes low on the SYNC_STAGES-th edge after release
    // Extra stages give a metastable first flop time to settle
    assign sync_rst = rst_chain[SYNC_STAGES-1];

endmodule
